/* verilog/rv_isa_pkg.sv */
// RV32I encodings and base widths; referenced by scoped name wherever the ISA is decoded.
package rv_isa_pkg;

  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // ####################
  // Base types
  // ####################

  typedef logic [XLEN-1:0] word_t;
  typedef logic [XLEN-1:0] pc_t;
  typedef logic [ILEN-1:0] inst_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      opcode_t;

  // ####################
  // Opcodes
  // ####################

  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_JAL    = 7'b1101111;
  localparam opcode_t OPC_JALR   = 7'b1100111;
  localparam opcode_t OPC_SYSTEM = 7'b1110011;

  // Conditional branch funct3.
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // ####################
  // System instructions
  // ####################

  // Matched against the whole word, so no field decode is needed.
  localparam inst_t INST_ECALL = 32'h0000_0073;
  localparam inst_t INST_MRET  = 32'h3020_0073;

  localparam pc_t INST_BYTES = 32'd4;  // No compressed instructions.

endpackage

/* verilog/bru_pkg.sv */
// Branch unit internal codes and pipeline bundles; shared by the RTL and the testbench.
package bru_pkg;

  // Branch function, same code points as the older branch unit.
  typedef logic [2:0] brfunc_t;

  localparam brfunc_t BRF_JAL  = 3'b000;
  localparam brfunc_t BRF_JALR = 3'b001;
  localparam brfunc_t BRF_BEQ  = 3'b010;
  localparam brfunc_t BRF_BNE  = 3'b011;
  localparam brfunc_t BRF_BLT  = 3'b100;
  localparam brfunc_t BRF_BGE  = 3'b101;
  localparam brfunc_t BRF_BLTU = 3'b110;
  localparam brfunc_t BRF_BGEU = 3'b111;

  // Immediate format select.
  typedef logic [1:0] immk_t;

  localparam immk_t IMMK_I = 2'd0;
  localparam immk_t IMMK_B = 2'd1;
  localparam immk_t IMMK_J = 2'd2;

  // ####################
  // Pipeline bundles
  // ####################

  typedef struct packed {
    rv_isa_pkg::inst_t inst;
    rv_isa_pkg::pc_t   pc;
    rv_isa_pkg::word_t rs1;
    rv_isa_pkg::word_t rs2;
  } bru_issue_t;

  typedef struct packed {
    logic              bren;
    brfunc_t           brfunc;
    logic              ecall;
    logic              mret;
    rv_isa_pkg::pc_t   pc;
    rv_isa_pkg::word_t rs1;
    rv_isa_pkg::word_t rs2;
    rv_isa_pkg::word_t imm;
  } bru_op_t;

  typedef struct packed {
    logic            taken;
    rv_isa_pkg::pc_t target;
    logic            trap;  // Ecall.
    logic            tret;  // Mret.
  } bru_res_t;

endpackage

/* verilog/bru_imm_gen.sv */
// Immediate generator: picks the I, B or J field of an instruction and sign-extends it.
`timescale 1ns/1ns

module bru_imm_gen (
  input  rv_isa_pkg::inst_t i_inst,
  input  bru_pkg::immk_t    i_immk,
  output rv_isa_pkg::word_t o_imm
);

  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_b;
  rv_isa_pkg::word_t imm_j;

  // I format, jalr offset.
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};

  // B format. Bit 0 is always zero.
  assign imm_b = {
    {19{i_inst[31]}},
    i_inst[31],
    i_inst[7],
    i_inst[30:25],
    i_inst[11:8],
    1'b0
  };

  // J format.
  assign imm_j = {
    {11{i_inst[31]}},
    i_inst[31],
    i_inst[19:12],
    i_inst[20],
    i_inst[30:21],
    1'b0
  };

  always_comb begin
    case (i_immk)
      bru_pkg::IMMK_B: o_imm = imm_b;
      bru_pkg::IMMK_J: o_imm = imm_j;
      default:         o_imm = imm_i;  // IMMK_I and the spare code.
    endcase
  end

endmodule

/* verilog/bru_cmp.sv */
// Branch comparator and target adder; works combinationally on the registered stage-1 op.
`timescale 1ns/1ns

module bru_cmp (
  input  bru_pkg::bru_op_t i_op,
  output logic             o_br_taken,
  output rv_isa_pkg::pc_t  o_br_target
);

  rv_isa_pkg::word_t rs2_neg;
  rv_isa_pkg::word_t diff;
  logic              carry;
  logic              overflow;
  logic              zero;
  logic              signed_less;
  logic              unsigned_less;
  logic              cond;
  rv_isa_pkg::word_t base;
  rv_isa_pkg::word_t jump_sum;
  rv_isa_pkg::pc_t   jump_target;

  // ####################
  // Subtractor
  // ####################

  assign rs2_neg         = ~i_op.rs2 + 32'd1;
  assign {carry, diff}   = {1'b0, i_op.rs1} + {1'b0, rs2_neg};

  // Operand signs differ and the result flips away from rs1.
  assign overflow        = (i_op.rs1[31] != i_op.rs2[31]) && (diff[31] != i_op.rs1[31]);
  assign zero            = ~(|diff);
  assign signed_less     = diff[31] ^ overflow;

  // No carry out means a borrow. A zero rs2 negates to zero and never carries.
  assign unsigned_less   = ~carry & (|i_op.rs2);

  // ####################
  // Condition table
  // ####################

  always_comb begin
    case (i_op.brfunc)
      bru_pkg::BRF_JAL:  cond = 1'b1;
      bru_pkg::BRF_JALR: cond = 1'b1;
      bru_pkg::BRF_BEQ:  cond = zero;
      bru_pkg::BRF_BNE:  cond = ~zero;
      bru_pkg::BRF_BLT:  cond = signed_less;
      bru_pkg::BRF_BGE:  cond = ~signed_less;
      bru_pkg::BRF_BLTU: cond = unsigned_less;
      default:           cond = ~unsigned_less;  // BGEU.
    endcase
  end

  assign o_br_taken = i_op.bren & cond;

  // ####################
  // Target adder
  // ####################

  assign base     = (i_op.brfunc == bru_pkg::BRF_JALR) ? i_op.rs1 : i_op.pc;
  assign jump_sum = base + i_op.imm;

  always_comb begin
    jump_target = jump_sum;
    if (i_op.brfunc == bru_pkg::BRF_JALR) begin
      jump_target[0] = 1'b0;  // ISA clears the low bit on jalr.
    end
  end

  // Not taken, or nothing recognized, steps to the next instruction.
  assign o_br_target = o_br_taken ? jump_target : i_op.pc + rv_isa_pkg::INST_BYTES;

endmodule

/* verilog/bru_trap_csr.sv */
// Machine trap registers mepc and mtvec; supplies the ecall or mret target to stage 2.
`timescale 1ns/1ns

module bru_trap_csr (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_csr_wr,
  input  rv_isa_pkg::word_t i_csr_wdata,
  input  logic              i_ecall_commit,
  input  rv_isa_pkg::pc_t   i_epc,
  input  logic              i_mret,
  output rv_isa_pkg::pc_t   o_ep_target
);

  rv_isa_pkg::pc_t   mepc;
  rv_isa_pkg::word_t mtvec;

  // ####################
  // mepc
  // ####################

  // Captured on the edge that retires the ecall, so a following mret sees it.
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mepc <= '0;
    end else if (i_ecall_commit) begin
      mepc <= i_epc;
    end
  end

  // ####################
  // mtvec
  // ####################

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mtvec <= '0;
    end else if (i_csr_wr) begin
      mtvec <= i_csr_wdata;  // Direct mode only.
    end
  end

  // Read of the current values; a same-cycle write lands on the next edge.
  assign o_ep_target = i_mret ? mepc : mtvec;

endmodule

/* verilog/bru_ctrl.sv */
// Branch unit control: decodes each issued instruction and holds the two pipeline stages.
`timescale 1ns/1ns

module bru_ctrl (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_issue,
  input  bru_pkg::bru_issue_t i_issue_data,
  input  rv_isa_pkg::word_t   i_imm,
  input  logic                i_br_taken,
  input  rv_isa_pkg::pc_t     i_br_target,
  input  rv_isa_pkg::pc_t     i_ep_target,
  output bru_pkg::immk_t      o_immk,
  output logic                o_op_vld,
  output bru_pkg::bru_op_t    o_op,
  output logic                o_res,
  output bru_pkg::bru_res_t   o_res_data
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  logic                is_system;
  logic                dec_bren;
  bru_pkg::brfunc_t    dec_brfunc;
  logic                dec_ecall;
  logic                dec_mret;
  logic                ep_sel;

  // ####################
  // Decode
  // ####################

  assign opcode    = i_issue_data.inst[6:0];
  assign funct3    = i_issue_data.inst[14:12];
  assign is_system = (opcode == rv_isa_pkg::OPC_SYSTEM);
  assign dec_ecall = is_system && (i_issue_data.inst == rv_isa_pkg::INST_ECALL);
  assign dec_mret  = is_system && (i_issue_data.inst == rv_isa_pkg::INST_MRET);

  always_comb begin
    dec_bren   = 1'b0;
    dec_brfunc = bru_pkg::BRF_JAL;
    o_immk     = bru_pkg::IMMK_I;
    case (opcode)
      rv_isa_pkg::OPC_BRANCH: begin
        o_immk   = bru_pkg::IMMK_B;
        dec_bren = 1'b1;
        case (funct3)
          rv_isa_pkg::F3_BEQ:  dec_brfunc = bru_pkg::BRF_BEQ;
          rv_isa_pkg::F3_BNE:  dec_brfunc = bru_pkg::BRF_BNE;
          rv_isa_pkg::F3_BLT:  dec_brfunc = bru_pkg::BRF_BLT;
          rv_isa_pkg::F3_BGE:  dec_brfunc = bru_pkg::BRF_BGE;
          rv_isa_pkg::F3_BLTU: dec_brfunc = bru_pkg::BRF_BLTU;
          rv_isa_pkg::F3_BGEU: dec_brfunc = bru_pkg::BRF_BGEU;
          default:             dec_bren   = 1'b0;  // 010/011 reserved, falls through.
        endcase
      end
      rv_isa_pkg::OPC_JAL: begin
        o_immk     = bru_pkg::IMMK_J;
        dec_bren   = 1'b1;
        dec_brfunc = bru_pkg::BRF_JAL;
      end
      rv_isa_pkg::OPC_JALR: begin
        dec_bren   = 1'b1;
        dec_brfunc = bru_pkg::BRF_JALR;
      end
      default: ;
    endcase
  end

  // ####################
  // Stage 1
  // ####################

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_op_vld <= 1'b0;
    end else begin
      o_op_vld <= i_issue;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue) begin
      o_op.bren   <= dec_bren;
      o_op.brfunc <= dec_brfunc;
      o_op.ecall  <= dec_ecall;
      o_op.mret   <= dec_mret;
      o_op.pc     <= i_issue_data.pc;
      o_op.rs1    <= i_issue_data.rs1;
      o_op.rs2    <= i_issue_data.rs2;
      o_op.imm    <= i_imm;
    end
  end

  // ####################
  // Stage 2
  // ####################

  assign ep_sel = o_op.ecall | o_op.mret;  // Trap path wins over the comparator.

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_res <= 1'b0;
    end else begin
      o_res <= o_op_vld;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_op_vld) begin
      o_res_data.taken  <= i_br_taken | ep_sel;
      o_res_data.target <= ep_sel ? i_ep_target : i_br_target;
      o_res_data.trap   <= o_op.ecall;
      o_res_data.tret   <= o_op.mret;
    end
  end

endmodule

/* verilog/bru_top.sv */
// Branch resolution unit top level; one result per issue, two cycles later.
`timescale 1ns/1ns

module bru_top (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_issue,
  input  bru_pkg::bru_issue_t i_issue_data,
  input  logic                i_csr_wr,
  input  rv_isa_pkg::word_t   i_csr_wdata,
  output logic                o_res,
  output bru_pkg::bru_res_t   o_res_data
);

  bru_pkg::immk_t    immk;
  rv_isa_pkg::word_t imm;
  logic              op_vld;
  bru_pkg::bru_op_t  op;
  logic              br_taken;
  rv_isa_pkg::pc_t   br_target;
  rv_isa_pkg::pc_t   ep_target;

  bru_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_issue      (i_issue),
    .i_issue_data (i_issue_data),
    .i_imm        (imm),
    .i_br_taken   (br_taken),
    .i_br_target  (br_target),
    .i_ep_target  (ep_target),
    .o_immk       (immk),
    .o_op_vld     (op_vld),
    .o_op         (op),
    .o_res        (o_res),
    .o_res_data   (o_res_data)
  );

  bru_imm_gen u_imm_gen (
    .i_inst (i_issue_data.inst),
    .i_immk (immk),
    .o_imm  (imm)
  );

  bru_cmp u_cmp (
    .i_op        (op),
    .o_br_taken  (br_taken),
    .o_br_target (br_target)
  );

  bru_trap_csr u_trap_csr (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_csr_wr       (i_csr_wr),
    .i_csr_wdata    (i_csr_wdata),
    .i_ecall_commit (op_vld & op.ecall),  // Stage-2 ecall.
    .i_epc          (op.pc),
    .i_mret         (op.mret),
    .o_ep_target    (ep_target)
  );

endmodule

/* test/bru_model.svh */
// Reference model of the branch unit; included into the testbench module body.
`ifndef BRU_MODEL_SVH
`define BRU_MODEL_SVH

  // Machine trap registers as the ISA defines them.
  rv_isa_pkg::pc_t   ref_mepc;
  rv_isa_pkg::word_t ref_mtvec;

  function automatic rv_isa_pkg::word_t itype_imm(input rv_isa_pkg::inst_t inst);
    rv_isa_pkg::word_t v;
    v       = {32{inst[31]}};
    v[11:0] = inst[31:20];
    return v;
  endfunction

  function automatic rv_isa_pkg::word_t branch_offset(input rv_isa_pkg::inst_t inst);
    rv_isa_pkg::word_t v;
    v       = {32{inst[31]}};  // Bit 12 and up.
    v[11]   = inst[7];
    v[10:5] = inst[30:25];
    v[4:1]  = inst[11:8];
    v[0]    = 1'b0;
    return v;
  endfunction

  function automatic rv_isa_pkg::word_t jump_offset(input rv_isa_pkg::inst_t inst);
    rv_isa_pkg::word_t v;
    v        = {32{inst[31]}};  // Bit 20 and up.
    v[19:12] = inst[19:12];
    v[11]    = inst[20];
    v[10:1]  = inst[30:21];
    v[0]     = 1'b0;
    return v;
  endfunction

  // Expected result of one issue, in issue order; an ecall also moves its pc into mepc.
  function automatic bru_pkg::bru_res_t expected_result(input bru_pkg::bru_issue_t iss);
    bru_pkg::bru_res_t   res;
    rv_isa_pkg::opcode_t opc;
    logic                cond;
    opc        = iss.inst[6:0];
    cond       = 1'b0;
    res.taken  = 1'b0;
    res.target = iss.pc + rv_isa_pkg::INST_BYTES;
    res.trap   = 1'b0;
    res.tret   = 1'b0;
    if (iss.inst == rv_isa_pkg::INST_ECALL) begin
      res.taken  = 1'b1;
      res.target = ref_mtvec;
      res.trap   = 1'b1;
      ref_mepc   = iss.pc;
    end else if (iss.inst == rv_isa_pkg::INST_MRET) begin
      res.taken  = 1'b1;
      res.target = ref_mepc;
      res.tret   = 1'b1;
    end else if (opc == rv_isa_pkg::OPC_JAL) begin
      res.taken  = 1'b1;
      res.target = iss.pc + jump_offset(iss.inst);
    end else if (opc == rv_isa_pkg::OPC_JALR) begin
      res.taken  = 1'b1;
      res.target = (iss.rs1 + itype_imm(iss.inst)) & ~32'd1;
    end else if (opc == rv_isa_pkg::OPC_BRANCH) begin
      case (iss.inst[14:12])
        rv_isa_pkg::F3_BEQ:  cond = (iss.rs1 == iss.rs2);
        rv_isa_pkg::F3_BNE:  cond = (iss.rs1 != iss.rs2);
        rv_isa_pkg::F3_BLT:  cond = ($signed(iss.rs1) < $signed(iss.rs2));
        rv_isa_pkg::F3_BGE:  cond = ($signed(iss.rs1) >= $signed(iss.rs2));
        rv_isa_pkg::F3_BLTU: cond = (iss.rs1 < iss.rs2);
        rv_isa_pkg::F3_BGEU: cond = (iss.rs1 >= iss.rs2);
        default:             cond = 1'b0;  // Reserved funct3.
      endcase
      if (cond) begin
        res.taken  = 1'b1;
        res.target = iss.pc + branch_offset(iss.inst);
      end
    end
    return res;
  endfunction

`endif

/* test/tb_bru_top.sv */
// Self-checking testbench for the branch unit; random instructions scored against a model.
`timescale 1ns/1ns

module tb_bru_top;

  localparam int N_BRANCH    = 400;
  localparam int N_JUMP      = 100;
  localparam int N_TRAP      = 8;  // Rounds of mtvec write, ecall and mret.
  localparam int N_OTHER     = 100;
  localparam int N_MIXED     = 300;
  localparam int N_ISSUES    = N_BRANCH + N_JUMP + 2 * N_TRAP + N_OTHER + N_MIXED;
  localparam int MAX_CYCLES  = N_ISSUES * 2 + 200;
  localparam int KIND_BRANCH = 0;
  localparam int KIND_JAL    = 1;
  localparam int KIND_JALR   = 2;
  localparam int KIND_ECALL  = 3;
  localparam int KIND_MRET   = 4;
  localparam int KIND_OTHER  = 5;

  logic                i_clk = 1'b0;
  logic                i_rst_n;
  logic                i_issue;
  bru_pkg::bru_issue_t i_issue_data;
  logic                i_csr_wr;
  rv_isa_pkg::word_t   i_csr_wdata;
  logic                o_res;
  bru_pkg::bru_res_t   o_res_data;

  logic [31:0]         lfsr_state;
  int                  cycle = 0;
  int                  errors = 0;
  int                  results = 0;
  int                  issued = 0;
  bru_pkg::bru_res_t   exp_q[$];
  int                  issue_cyc_q[$];
  bru_pkg::bru_res_t   mon_exp;
  int                  mon_cyc;

  `include "bru_model.svh"

  bru_top i_bru_top (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_issue      (i_issue),
    .i_issue_data (i_issue_data),
    .i_csr_wr     (i_csr_wr),
    .i_csr_wdata  (i_csr_wdata),
    .o_res        (o_res),
    .o_res_data   (o_res_data)
  );

  always #2 i_clk = ~i_clk;

  // ####################
  // Random numbers
  // ####################

  // 32-bit Fibonacci LFSR, taps 32 22 2 1.
  function automatic logic next_bit();
    logic fb;
    fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  function automatic rv_isa_pkg::word_t boundary_value();
    logic [31:0] r;
    r = rand_bits(3);
    case (r[2:0])
      3'd0:    r = 32'h8000_0000;
      3'd1:    r = 32'h7fff_ffff;
      3'd2:    r = 32'hffff_ffff;
      3'd3:    r = 32'h0000_0000;
      3'd4:    r = 32'h0000_0001;
      default: r = rand_bits(32);
    endcase
    return r;
  endfunction

  task automatic pick_operands(output rv_isa_pkg::word_t a, output rv_isa_pkg::word_t b);
    logic [31:0] r;
    r = rand_bits(3);
    a = rand_bits(32);
    b = rand_bits(32);
    case (r[2:0])
      3'd0, 3'd1: b = a;  // About a quarter equal.
      3'd2: b = '0;
      3'd3: begin
        a = boundary_value();
        b = boundary_value();
      end
      3'd4: b = a ^ 32'h8000_0000;  // Only the sign differs.
      default: ;
    endcase
  endtask

  function automatic rv_isa_pkg::inst_t make_inst(input int kind);
    logic [31:0]         r;
    logic [31:0]         t;
    rv_isa_pkg::opcode_t opc;
    rv_isa_pkg::inst_t   inst;
    r   = rand_bits(25);
    opc = rv_isa_pkg::OPC_BRANCH;
    if (kind == KIND_JAL) begin
      opc = rv_isa_pkg::OPC_JAL;
    end else if (kind == KIND_JALR) begin
      opc    = rv_isa_pkg::OPC_JALR;
      r[7:5] = 3'b000;  // funct3 lands on inst[14:12].
    end else if (kind == KIND_OTHER) begin
      opc = rv_isa_pkg::OPC_SYSTEM;
      while (opc == rv_isa_pkg::OPC_BRANCH || opc == rv_isa_pkg::OPC_JAL ||
             opc == rv_isa_pkg::OPC_JALR || opc == rv_isa_pkg::OPC_SYSTEM) begin
        t   = rand_bits(7);
        opc = t[6:0];
      end
    end
    inst = {r[24:0], opc};
    if (kind == KIND_ECALL) inst = rv_isa_pkg::INST_ECALL;
    if (kind == KIND_MRET) inst = rv_isa_pkg::INST_MRET;
    return inst;
  endfunction

  function automatic int random_kind();
    logic [31:0] r;
    r = rand_bits(3);
    return (r[2:0] > 3'd5) ? KIND_BRANCH : int'(r[2:0]);
  endfunction

  // ####################
  // Drivers
  // ####################

  // All drivers start and end 1 ns after a rising edge.
  task automatic send_issue(input rv_isa_pkg::inst_t inst, input rv_isa_pkg::word_t rs1,
                            input rv_isa_pkg::word_t rs2);
    bru_pkg::bru_issue_t data;
    bru_pkg::bru_res_t   exp;
    logic [31:0]         r;
    int                  cyc;
    r         = rand_bits(30);
    data.inst = inst;
    data.pc   = {r[29:0], 2'b00};
    data.rs1  = rs1;
    data.rs2  = rs2;
    exp       = expected_result(data);
    cyc          = cycle;  // Cycle in which the issue is presented.
    i_issue      = 1'b1;
    i_issue_data = data;
    @(posedge i_clk);
    #1;
    i_issue = 1'b0;
    exp_q.push_back(exp);
    issue_cyc_q.push_back(cyc);
    issued++;
  endtask

  task automatic write_mtvec(input rv_isa_pkg::word_t value);
    i_csr_wr    = 1'b1;
    i_csr_wdata = value;
    ref_mtvec   = value;
    @(posedge i_clk);
    #1;
    i_csr_wr = 1'b0;
  endtask

  task automatic drain_pipeline();
    @(posedge i_clk);
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    #1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge i_clk);
    #1;
  endtask

  // ####################
  // Checking
  // ####################

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  always @(posedge i_clk) begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d results still missing", cycle, exp_q.size());
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Scoreboard, sampled on the falling edge.
  always @(negedge i_clk) begin
    if (!i_rst_n) begin
      if (o_res !== 1'b0) begin
        $display("o_res is not low during reset at %0t ns", $time);
        errors++;
      end
    end else if (o_res === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("Result at %0t ns with no instruction outstanding", $time);
        errors++;
      end else begin
        mon_exp = exp_q.pop_front();
        mon_cyc = issue_cyc_q.pop_front();
        check_value({31'b0, o_res_data.taken}, {31'b0, mon_exp.taken},
                    $sformatf("result %0d taken", results));
        check_value(o_res_data.target, mon_exp.target, $sformatf("result %0d target", results));
        check_value({31'b0, o_res_data.trap}, {31'b0, mon_exp.trap},
                    $sformatf("result %0d trap", results));
        check_value({31'b0, o_res_data.tret}, {31'b0, mon_exp.tret},
                    $sformatf("result %0d tret", results));
        check_value(cycle - mon_cyc, 32'd2, $sformatf("result %0d latency", results));
        results++;
      end
    end else if (o_res !== 1'b0) begin
      $display("o_res is unknown at %0t ns", $time);
      errors++;
    end
  end

  task automatic report_test(input string name, input int res0, input int err0);
    $display("%s: %0d results, %0d errors", name, results - res0, errors - err0);
  endtask

  // ####################
  // Tests
  // ####################

  task automatic branch_sweep();
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    int                k;
    for (k = 0; k < N_BRANCH; k++) begin
      pick_operands(a, b);
      send_issue(make_inst(KIND_BRANCH), a, b);
    end
    drain_pipeline();
  endtask

  task automatic jump_sweep();
    int k;
    for (k = 0; k < N_JUMP; k++) begin
      send_issue(make_inst(next_bit() ? KIND_JAL : KIND_JALR), rand_bits(32), rand_bits(32));
    end
    drain_pipeline();
  endtask

  task automatic trap_sequence();
    logic [31:0] r;
    int          k;
    for (k = 0; k < N_TRAP; k++) begin
      r = rand_bits(30);
      write_mtvec({r[29:0], 2'b00});
      send_issue(make_inst(KIND_ECALL), rand_bits(32), rand_bits(32));
      send_issue(make_inst(KIND_MRET), rand_bits(32), rand_bits(32));
      drain_pipeline();
    end
  endtask

  task automatic non_control_sweep();
    int k;
    for (k = 0; k < N_OTHER; k++) begin
      send_issue(make_inst(KIND_OTHER), rand_bits(32), rand_bits(32));
    end
    drain_pipeline();
  endtask

  task automatic mixed_stream();
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    int                k;
    for (k = 0; k < N_MIXED; k++) begin
      pick_operands(a, b);
      send_issue(make_inst(random_kind()), a, b);
    end
    drain_pipeline();
    idle_cycles(10);  // o_res must stay low here.
  endtask

  initial begin
    int res0;
    int err0;
    i_rst_n      = 1'b0;
    i_issue      = 1'b0;
    i_issue_data = '0;
    i_csr_wr     = 1'b0;
    i_csr_wdata  = '0;
    lfsr_state   = 32'd94281;
    ref_mepc     = '0;
    ref_mtvec    = '0;
    repeat (4) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;

    res0 = results;
    err0 = errors;
    branch_sweep();
    report_test("Conditional branches", res0, err0);
    res0 = results;
    err0 = errors;
    jump_sweep();
    report_test("Jumps", res0, err0);
    res0 = results;
    err0 = errors;
    trap_sequence();
    report_test("Traps", res0, err0);
    res0 = results;
    err0 = errors;
    non_control_sweep();
    report_test("Non-control instructions", res0, err0);
    res0 = results;
    err0 = errors;
    mixed_stream();
    report_test("Back-to-back mix", res0, err0);

    if (exp_q.size() != 0) begin
      $display("%0d issued instructions never produced a result", exp_q.size());
    end
    $display("Issued %0d, results %0d, errors %0d", issued, results, errors);
    if (errors == 0 && exp_q.size() == 0 && results == issued) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+test
verilog/rv_isa_pkg.sv
verilog/bru_pkg.sv
verilog/bru_imm_gen.sv
verilog/bru_cmp.sv
verilog/bru_trap_csr.sv
verilog/bru_ctrl.sv
verilog/bru_top.sv
test/tb_bru_top.sv

/* Makefile */
SIM      ?= verilator
TOP      ?= tb_bru_top
FILELIST ?= project.f
FLAGS    ?= --binary --timing -j 0
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
